//--- verilog/im2col_cfg_pkg.sv
package im2col_cfg_pkg;

    localparam int KERNEL_SIZE       = 6;    // 6x6 kernel only
    localparam int WORDS_PER_SLICE   = 9;    // 36 weights / 4 per word
    localparam int FILTERS_PER_GROUP = 10;

    // where the tile sits in the layer, decides column padding
    typedef enum logic [1:0] {
        tile_first,
        tile_middle,
        tile_last
    } tile_pos_t;

    // layer opcode
    typedef struct packed {
        logic [9:0]  in_row;
        logic [9:0]  in_column;
        logic [1:0]  stride;
        logic [1:0]  padding;
        tile_pos_t   tile_pos;
        logic [11:0] input_channel;
        logic [11:0] output_channel;
    } conv_cfg_t;

    typedef logic [15:0] count_t;    // loop counts, replay totals

endpackage

//--- verilog/im2col_data_pkg.sv
package im2col_data_pkg;

    localparam int LANES_PER_WORD = 4;    // weights per memory word

    typedef logic [15:0] weight_t;    // Q7.9
    typedef logic [63:0] mem_word_t;

    // one 6x6 slice, seen as memory words by the fetch unit
    // and as single weights by the conv array
    // weight k sits in word k/4, lane k%4, lane 0 low
    typedef union packed {
        mem_word_t [im2col_cfg_pkg::WORDS_PER_SLICE-1:0]                words;
        weight_t   [im2col_cfg_pkg::WORDS_PER_SLICE*LANES_PER_WORD-1:0] weights;
    } weight_vec_t;

endpackage

//--- verilog/conv_geometry.sv
`timescale 1ns/10ps

module conv_geometry
    import im2col_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      clear,
    input  logic      load,
    input  conv_cfg_t cfg,
    output count_t    replays
);

    localparam int POSITIONS_PER_REPLAY = 10;

    count_t      row_span;
    count_t      col_span;
    count_t      col_pad;
    count_t      step;
    count_t      rows;
    count_t      cols;
    logic [31:0] total;

    // only middle tiles get padding on the column edge
    assign col_pad  = (cfg.tile_pos == tile_middle) ? count_t'(cfg.padding) : '0;
    assign row_span = count_t'(cfg.in_row) + count_t'({cfg.padding, 1'b0});
    assign col_span = count_t'(cfg.in_column) + col_pad;
    assign step     = (cfg.stride == 2'd0) ? 16'd1 : count_t'(cfg.stride);    // stride 0 read as 1

    assign rows = (row_span < count_t'(KERNEL_SIZE)) ? '0 :
                  (row_span - count_t'(KERNEL_SIZE)) / step + 16'd1;
    assign cols = (col_span < count_t'(KERNEL_SIZE)) ? '0 :
                  (col_span - count_t'(KERNEL_SIZE)) / step + 16'd1;

    assign total = 32'(rows) * 32'(cols);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            replays <= '0;
        end else if (clear) begin
            replays <= '0;
        end else if (load) begin
            replays <= count_t'(total / 32'(POSITIONS_PER_REPLAY));
        end
    end

endmodule

//--- verilog/weight_sequencer.sv
`timescale 1ns/10ps

module weight_sequencer
    import im2col_cfg_pkg::*, im2col_data_pkg::*;
#(
    parameter int ADDR_WIDTH = 14
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clear,
    input  logic                  conv_en,
    input  logic                  weight_pause,
    input  conv_cfg_t             cfg,
    input  count_t                replays,
    output logic                  load,
    output logic                  fetch_start,
    output logic [ADDR_WIDTH-1:0] fetch_base,
    input  logic                  fetch_done,
    input  weight_vec_t           fetch_vec,
    output logic                  vector_valid,
    output weight_vec_t           vector,
    output logic                  done
);

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    typedef enum logic [2:0] {
        st_idle,
        st_size,
        st_fetch,
        st_hold,
        st_done
    } state_t;

    state_t     state;
    logic [3:0] filter_cnt;
    count_t     channel_cnt;
    count_t     replay_cnt;
    count_t     group_first;    // first filter of the current group
    addr_t      group_base;
    addr_t      filter_off;
    addr_t      channel_off;
    addr_t      filter_step;
    logic       last_filter;
    logic       last_channel;
    logic       last_replay;
    logic       last_group;
    logic       last_slice;
    logic       empty_run;
    logic       emit;

    assign filter_step = addr_t'(cfg.input_channel) * addr_t'(WORDS_PER_SLICE);
    assign fetch_base  = group_base + filter_off + channel_off;
    assign load        = (state == st_idle) && conv_en;

    assign last_filter  = filter_cnt == 4'(FILTERS_PER_GROUP - 1);
    assign last_channel = channel_cnt == count_t'(cfg.input_channel) - 16'd1;
    assign last_replay  = replay_cnt == replays - 16'd1;
    assign last_group   = (group_first + count_t'(2 * FILTERS_PER_GROUP)) >
                          count_t'(cfg.output_channel);
    assign last_slice   = last_filter && last_channel && last_replay && last_group;

    assign empty_run = (replays == '0) || (cfg.input_channel == '0) ||
                       (count_t'(cfg.output_channel) < count_t'(FILTERS_PER_GROUP));

    // vector goes out on the first unpaused cycle once it is assembled
    assign emit = !weight_pause && ((state == st_fetch && fetch_done) || state == st_hold);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state        <= st_idle;
            fetch_start  <= 1'b0;
            vector_valid <= 1'b0;
            done         <= 1'b0;
            filter_cnt   <= '0;
            channel_cnt  <= '0;
            replay_cnt   <= '0;
            group_first  <= '0;
            group_base   <= '0;
            filter_off   <= '0;
            channel_off  <= '0;
        end else if (clear) begin
            state        <= st_idle;
            fetch_start  <= 1'b0;
            vector_valid <= 1'b0;
            done         <= 1'b0;
            filter_cnt   <= '0;
            channel_cnt  <= '0;
            replay_cnt   <= '0;
            group_first  <= '0;
            group_base   <= '0;
            filter_off   <= '0;
            channel_off  <= '0;
        end else begin
            fetch_start  <= 1'b0;
            vector_valid <= 1'b0;
            done         <= (state == st_done);    // one cycle behind the last vector

            case (state)
                st_idle: begin
                    if (conv_en) begin
                        state <= st_size;    // replays registered this edge
                    end
                end
                st_size: begin
                    if (empty_run) begin
                        state <= st_done;
                    end else begin
                        fetch_start <= 1'b1;
                        state       <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (fetch_done && weight_pause) begin
                        state <= st_hold;
                    end
                end
                st_hold, st_done: begin
                end
                default: begin
                    state <= st_idle;
                end
            endcase

            if (emit) begin
                vector_valid <= 1'b1;
                if (last_slice) begin
                    state <= st_done;
                end else begin
                    fetch_start <= 1'b1;
                    state       <= st_fetch;
                end

                // filter innermost, then channel, replay, group
                if (!last_filter) begin
                    filter_cnt <= filter_cnt + 4'd1;
                    filter_off <= filter_off + filter_step;
                end else begin
                    filter_cnt <= '0;
                    filter_off <= '0;
                    if (!last_channel) begin
                        channel_cnt <= channel_cnt + 16'd1;
                        channel_off <= channel_off + addr_t'(WORDS_PER_SLICE);
                    end else begin
                        channel_cnt <= '0;
                        channel_off <= '0;
                        if (!last_replay) begin
                            replay_cnt <= replay_cnt + 16'd1;
                        end else begin
                            replay_cnt <= '0;
                            if (last_group) begin
                                group_first <= '0;
                                group_base  <= '0;
                            end else begin
                                group_first <= group_first + count_t'(FILTERS_PER_GROUP);
                                group_base  <= group_base + filter_off + filter_step;    // +10 slices
                            end
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            vector <= fetch_vec;
        end
    end

endmodule

//--- verilog/weight_fetch.sv
`timescale 1ns/10ps

module weight_fetch
    import im2col_cfg_pkg::*, im2col_data_pkg::*;
#(
    parameter int ADDR_WIDTH = 14
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clear,
    input  logic                  fetch_start,
    input  logic [ADDR_WIDTH-1:0] fetch_base,
    output logic                  rd_en,
    output logic [ADDR_WIDTH-1:0] rd_addr,
    input  mem_word_t             rd_data,
    output logic                  fetch_done,
    output weight_vec_t           fetch_vec
);

    localparam logic [3:0] LAST_WORD = 4'(WORDS_PER_SLICE - 1);

    logic [3:0] word_cnt;     // word being requested
    logic [3:0] store_idx;    // word arriving on rd_data
    logic       store_en;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rd_en      <= 1'b0;
            rd_addr    <= '0;
            word_cnt   <= '0;
            store_en   <= 1'b0;
            store_idx  <= '0;
            fetch_done <= 1'b0;
        end else if (clear) begin
            rd_en      <= 1'b0;
            rd_addr    <= '0;
            word_cnt   <= '0;
            store_en   <= 1'b0;
            store_idx  <= '0;
            fetch_done <= 1'b0;
        end else begin
            // memory answers one cycle after the request
            store_en   <= rd_en;
            store_idx  <= word_cnt;
            fetch_done <= store_en && (store_idx == LAST_WORD);

            if (fetch_start) begin
                rd_en    <= 1'b1;
                rd_addr  <= fetch_base;
                word_cnt <= '0;
            end else if (rd_en) begin
                rd_addr  <= rd_addr + ADDR_WIDTH'(1);
                word_cnt <= word_cnt + 4'd1;
                if (word_cnt == LAST_WORD) begin
                    rd_en <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_en) begin
            fetch_vec.words[store_idx] <= rd_data;
        end
    end

endmodule

//--- verilog/weight_im2col.sv
`timescale 1ns/10ps

module weight_im2col
    import im2col_cfg_pkg::*, im2col_data_pkg::*;
#(
    parameter int ADDR_WIDTH = 14
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clear,
    input  logic                  conv_en,
    input  conv_cfg_t             cfg,
    output logic                  rd_en,
    output logic [ADDR_WIDTH-1:0] rd_addr,
    input  mem_word_t             rd_data,
    input  logic                  weight_pause,
    output logic                  vector_valid,
    output weight_vec_t           vector,
    output logic                  done
);

    logic                  load;
    count_t                replays;
    logic                  fetch_start;
    logic [ADDR_WIDTH-1:0] fetch_base;
    logic                  fetch_done;
    weight_vec_t           fetch_vec;

    conv_geometry conv_geometry_i (
        .clk     (clk),
        .reset   (reset),
        .clear   (clear),
        .load    (load),
        .cfg     (cfg),
        .replays (replays)
    );

    weight_sequencer #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) weight_sequencer_i (
        .clk          (clk),
        .reset        (reset),
        .clear        (clear),
        .conv_en      (conv_en),
        .weight_pause (weight_pause),
        .cfg          (cfg),
        .replays      (replays),
        .load         (load),
        .fetch_start  (fetch_start),
        .fetch_base   (fetch_base),
        .fetch_done   (fetch_done),
        .fetch_vec    (fetch_vec),
        .vector_valid (vector_valid),
        .vector       (vector),
        .done         (done)
    );

    weight_fetch #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) weight_fetch_i (
        .clk         (clk),
        .reset       (reset),
        .clear       (clear),
        .fetch_start (fetch_start),
        .fetch_base  (fetch_base),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .fetch_done  (fetch_done),
        .fetch_vec   (fetch_vec)
    );

endmodule

//--- test/weight_mem.sv
`timescale 1ns/10ps

module weight_mem
    import im2col_data_pkg::*;
#(
    parameter int ADDR_WIDTH = 14
) (
    input  logic                  clk,
    input  logic                  rd_en,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    output mem_word_t             rd_data
);

    mem_word_t mem [2**ADDR_WIDTH];    // written by the testbench before reset ends

    // word comes back one cycle after the request
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- test/weight_im2col_chk.sv
`timescale 1ns/10ps

module weight_im2col_chk (
    input logic clk,
    input logic reset,
    input logic clear,
    input logic rd_en,
    input logic vector_valid,
    input logic done,
    input logic weight_pause
);

    logic [3:0] read_run;    // rd_en cycles in a row

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            read_run <= '0;
        end else if (!rd_en || clear) begin
            read_run <= '0;
        end else if (read_run != 4'hf) begin
            read_run <= read_run + 4'd1;
        end
    end

    valid_pulse: assert property (@(posedge clk) disable iff (!reset)
        vector_valid |=> !vector_valid)
        else $error("vector_valid high for more than one cycle");

    pause_blocks: assert property (@(posedge clk) disable iff (!reset)
        weight_pause |=> !vector_valid)
        else $error("vector_valid right after weight_pause");

    read_burst: assert property (@(posedge clk) disable iff (!reset)
        !(rd_en && read_run >= 4'd9))
        else $error("rd_en high for more than nine cycles");

    idle_when_done: assert property (@(posedge clk) disable iff (!reset)
        done |-> !rd_en)
        else $error("rd_en high while done");

endmodule

//--- test/weight_im2col_tb.sv
`timescale 1ns/10ps

module weight_im2col_tb
    import im2col_cfg_pkg::*, im2col_data_pkg::*;
();

    localparam int ADDR_WIDTH = 14;
    localparam int MEM_WORDS  = 2 ** ADDR_WIDTH;

    logic                  clk;
    logic                  reset;
    logic                  clear;
    logic                  conv_en;
    conv_cfg_t             cfg;
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr;
    mem_word_t             rd_data;
    logic                  weight_pause;
    logic                  vector_valid;
    weight_vec_t           vector;
    logic                  done;

    logic [31:0] lcg_state;
    mem_word_t   model_mem [MEM_WORDS];    // own copy of the weight memory
    int          expected_bases [$];       // slice base addresses still to come
    int          error_count;
    int          check_count;

    weight_im2col #(.ADDR_WIDTH(ADDR_WIDTH)) weight_im2col_i (
        .clk(clk), .reset(reset), .clear(clear), .conv_en(conv_en), .cfg(cfg),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data), .weight_pause(weight_pause),
        .vector_valid(vector_valid), .vector(vector), .done(done)
    );

    weight_mem #(.ADDR_WIDTH(ADDR_WIDTH)) weight_mem_i (
        .clk(clk), .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    bind weight_im2col weight_im2col_chk weight_im2col_chk_i (
        .clk(clk), .reset(reset), .clear(clear), .rd_en(rd_en),
        .vector_valid(vector_valid), .done(done), .weight_pause(weight_pause)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // replays = rows * columns / 10, column padding only on middle tiles
    function automatic count_t expected_replays(input conv_cfg_t c);
        int rows;
        int cols;
        int col_pad;
        col_pad = (c.tile_pos == tile_middle) ? int'(c.padding) : 0;
        rows    = (int'(c.in_row) + 2 * int'(c.padding) - 6) / int'(c.stride) + 1;
        cols    = (int'(c.in_column) + col_pad - 6) / int'(c.stride) + 1;
        return count_t'(rows * cols / 10);
    endfunction

    // weight k taken from word k/4, lane k%4
    function automatic weight_vec_t predict_vector(input int base);
        weight_vec_t           v;
        mem_word_t             w;
        logic [ADDR_WIDTH-1:0] addr;
        for (int k = 0; k < 36; k++) begin
            addr = ADDR_WIDTH'(base + k / 4);
            w    = model_mem[addr];
            v.weights[6'(k)] = w[16 * (k % 4) +: 16];
        end
        return v;
    endfunction

    task automatic build_expected(input conv_cfg_t c, input count_t replays);
        int ic;
        ic = int'(c.input_channel);
        expected_bases.delete();
        for (int g = 0; g < int'(c.output_channel) / 10; g++) begin
            for (int r = 0; r < int'(replays); r++) begin
                for (int ch = 0; ch < ic; ch++) begin
                    for (int f = 0; f < 10; f++) begin
                        expected_bases.push_back(g * ic * 90 + f * ic * 9 + ch * 9);
                    end
                end
            end
        end
    endtask

    task automatic compare_vector(input string test, input weight_vec_t expected,
                                  input weight_vec_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %s: expected %h actual %h", test, expected, actual);
        end
    endtask

    task automatic compare_count(input string test, input count_t expected, input count_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %s: expected %0d actual %0d", test, expected, actual);
        end
    endtask

    task automatic compare_flag(input string test, input string what, input logic expected,
                                input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %s: %s expected %b actual %b", test, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string test, input string what);
        error_count++;
        $display("%s: %s", test, what);
    endtask

    task automatic report_test(input string test, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %s: ok", test);
        end else begin
            $display("test %s: %0d errors", test, error_count - errors_before);
        end
    endtask

    task automatic start_run(input conv_cfg_t c);
        @(posedge clk);
        cfg   <= c;
        clear <= 1'b1;
        @(posedge clk);
        clear   <= 1'b0;
        conv_en <= 1'b1;
        @(posedge clk);
        conv_en <= 1'b0;
    endtask

    task automatic collect_vectors(input string test, input logic random_pause,
                                   output count_t seen);
        int          limit;
        int          cycles;
        logic        finished;
        logic [31:0] r;
        seen     = '0;
        cycles   = 0;
        finished = 1'b0;
        limit    = 64 * expected_bases.size() + 200;
        while (!finished) begin
            @(posedge clk);
            if (random_pause) begin
                r = next_random();
                weight_pause <= r[20];
            end
            @(negedge clk);
            if (vector_valid) begin
                if (expected_bases.size() == 0) begin
                    report_failure(test, "got a vector after the expected sequence ended");
                end else begin
                    compare_vector(test, predict_vector(expected_bases.pop_front()), vector);
                end
                seen = seen + 16'd1;
            end
            cycles++;
            if (done) begin
                finished = 1'b1;
            end else if (cycles >= limit) begin
                report_failure(test, "timed out waiting for done");
                finished = 1'b1;
            end
        end
        @(posedge clk);
        weight_pause <= 1'b0;
        if (expected_bases.size() != 0) begin
            report_failure(test, $sformatf("%0d vectors never arrived", expected_bases.size()));
        end
    endtask

    // full run; checks replays, every vector and the vector count
    task automatic run_case(input string test, input conv_cfg_t c, input logic random_pause);
        count_t reps;
        count_t seen;
        int     total;
        reps  = expected_replays(c);
        total = int'(c.output_channel) / 10 * int'(reps) * int'(c.input_channel) * 10;
        build_expected(c, reps);
        start_run(c);
        collect_vectors(test, random_pause, seen);
        compare_count(test, reps, weight_im2col_i.replays);
        compare_count(test, count_t'(total), seen);
    endtask

    task automatic single_group_test();
        conv_cfg_t c;
        int        errs;
        errs = error_count;
        c    = '{10'd7, 10'd10, 2'd1, 2'd0, tile_first, 12'd1, 12'd10};    // 1 replay
        run_case("single_group", c, 1'b0);
        report_test("single_group", errs);
    endtask

    task automatic ordering_test();
        conv_cfg_t c;
        int        errs;
        errs = error_count;
        c    = '{10'd9, 10'd10, 2'd1, 2'd0, tile_first, 12'd2, 12'd20};    // 2 replays
        run_case("ordering", c, 1'b0);
        report_test("ordering", errs);
    endtask

    task automatic geometry_test();
        conv_cfg_t c;
        int        errs;
        errs = error_count;
        c    = '{10'd9, 10'd10, 2'd1, 2'd0, tile_first, 12'd1, 12'd10};
        run_case("geometry", c, 1'b0);
        c    = '{10'd9, 10'd9, 2'd3, 2'd3, tile_middle, 12'd2, 12'd10};
        run_case("geometry", c, 1'b0);
        c    = '{10'd9, 10'd9, 2'd3, 2'd3, tile_last, 12'd1, 12'd10};    // no replays
        run_case("geometry", c, 1'b0);
        c    = '{10'd12, 10'd8, 2'd2, 2'd1, tile_middle, 12'd1, 12'd20};
        run_case("geometry", c, 1'b0);
        report_test("geometry", errs);
    endtask

    task automatic pause_test();
        conv_cfg_t c;
        int        errs;
        errs = error_count;
        c    = '{10'd9, 10'd10, 2'd1, 2'd0, tile_first, 12'd2, 12'd20};
        run_case("pause", c, 1'b1);
        report_test("pause", errs);
    endtask

    task automatic clear_test();
        conv_cfg_t c;
        int        errs;
        int        seen;
        int        cycles;
        logic      rd_seen;
        logic      valid_seen;
        logic      done_seen;
        errs       = error_count;
        seen       = 0;
        cycles     = 0;
        rd_seen    = 1'b0;
        valid_seen = 1'b0;
        done_seen  = 1'b0;
        c          = '{10'd9, 10'd10, 2'd1, 2'd0, tile_first, 12'd2, 12'd20};
        start_run(c);
        while (seen < 3 && cycles < 200) begin
            @(negedge clk);
            if (vector_valid) begin
                seen++;
            end
            cycles++;
        end
        if (seen < 3) begin
            report_failure("clear", "timed out waiting for the first vectors");
        end
        @(posedge clk);
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        // the interrupted run would have ended well inside this window
        for (int i = 0; i < 1200; i++) begin
            @(negedge clk);
            rd_seen    = rd_seen | rd_en;
            valid_seen = valid_seen | vector_valid;
            done_seen  = done_seen | done;
        end
        compare_flag("clear", "rd_en", 1'b0, rd_seen);
        compare_flag("clear", "vector_valid", 1'b0, valid_seen);
        compare_flag("clear", "done", 1'b0, done_seen);
        run_case("clear", c, 1'b0);    // restart from the first slice
        report_test("clear", errs);
    endtask

    task automatic preload_memory();
        logic [31:0]           hi;
        logic [31:0]           lo;
        logic [ADDR_WIDTH-1:0] addr;
        for (int a = 0; a < MEM_WORDS; a++) begin
            addr                  = ADDR_WIDTH'(a);
            hi                    = next_random();
            lo                    = next_random();
            model_mem[addr]       = {hi, lo};
            weight_mem_i.mem[addr] = {hi, lo};
        end
    endtask

    initial begin
        reset        = 1'b0;
        clear        = 1'b0;
        conv_en      = 1'b0;
        weight_pause = 1'b0;
        cfg          = '0;
        error_count  = 0;
        check_count  = 0;
        lcg_state    = 32'h44bb_76b2;
        preload_memory();
        repeat (4) @(posedge clk);
        reset <= 1'b1;
        single_group_test();
        ordering_test();
        geometry_test();
        pause_test();
        clear_test();
        $display("tests 5, checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- im2col_weights.f
verilog/im2col_cfg_pkg.sv
verilog/im2col_data_pkg.sv
verilog/conv_geometry.sv
verilog/weight_sequencer.sv
verilog/weight_fetch.sv
verilog/weight_im2col.sv
test/weight_mem.sv
test/weight_im2col_chk.sv
test/weight_im2col_tb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = weight_im2col_tb
FLIST = im2col_weights.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || echo "Simulation failed" >> $(LOG)
	cat $(LOG)
	! grep -q "Simulation failed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
